// ==== verilog.f ====
+incdir+tests
source/mips_pkg.sv
source/mips_control.sv
source/mips_regfile.sv
source/mips_alu.sv
source/mips_pc_unit.sv
source/mips_core.sv
tests/mips_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the MIPS core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module mips_core_tb \
	-f verilog.f -o mips_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/mips_sim > sim.log 2>&1
grep -q '\*\*\* PASSED \*\*\*' sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// ==== tests/mips_program.svh ====
// Program, data memory and expected per-cycle trace for the MIPS core testbench, included in its body

localparam int PROG_LEN   = 50;
localparam int DATA_LEN   = 8;
localparam int STEP_COUNT = 48;

// Four instruction words per line, starting at address 0
localparam logic [31:0] PROGRAM [PROG_LEN] = '{
	32'h3C017FFF, 32'h3421FFFF, 32'h34020001, 32'h00221820,  // lui, ori, ori, add
	32'hAC030040, 32'h00222021, 32'hAC040044, 32'h00412822,  // sw, addu, sw, sub
	32'hAC050048, 32'h20260001, 32'hAC06004C, 32'h00A2382A,  // sw, addi, sw, slt
	32'hAC070050, 32'h00A2402B, 32'hAC080054, 32'h28A90001,  // sw, sltu, sw, slti
	32'hAC090058, 32'h2CAA0001, 32'hAC0A005C, 32'h00055903,  // sw, sltiu, sw, sra
	32'hAC0B0060, 32'h00056102, 32'hAC0C0064, 32'h00026FC0,  // sw, srl, sw, sll
	32'hAC0D0068, 32'h00A17024, 32'hAC0E006C, 32'h00A27825,  // sw, and, sw, or
	32'hAC0F0070, 32'h00A18026, 32'hAC100074, 32'h00A28827,  // sw, xor, sw, nor
	32'hAC110078, 32'h00459023, 32'hAC12007C, 32'h30B3FFFF,  // sw, subu, sw, andi
	32'hAC130080, 32'h38B48000, 32'hAC140084, 32'h24350001,  // sw, xori, sw, addiu
	32'hAC150088, 32'h10420001, 32'hAC0200F0, 32'h14420001,  // sw, beq, marker, bne
	32'h0800002E, 32'hAC0200F4, 32'h8C160008, 32'hAC16008C,  // j, marker, lw, sw
	32'h20000005, 32'hAC000090                               // addi into $zero, sw
};

// Data words at byte addresses 0x00 to 0x1c
localparam logic [31:0] DATA [DATA_LEN] = '{
	32'h11111111, 32'h22222222, 32'h5A5A1234, 32'h44444444,
	32'h55555555, 32'h66666666, 32'h77777777, 32'h88888888
};

typedef struct packed {
	logic [31:0] pc;
	logic        we;
	logic [31:0] addr;
	logic [31:0] data;
	logic        ovf;
} step_t;

// Columns are pc, memwrite, store address, store data, overflow
localparam step_t STEPS [STEP_COUNT] = '{
	'{32'h00, 1'b0, 32'h00, 32'h00000000, 1'b0}, '{32'h04, 1'b0, 32'h00, 32'h00000000, 1'b0},
	'{32'h08, 1'b0, 32'h00, 32'h00000000, 1'b0}, '{32'h0c, 1'b0, 32'h00, 32'h00000000, 1'b1},
	'{32'h10, 1'b1, 32'h40, 32'h80000000, 1'b0}, '{32'h14, 1'b0, 32'h00, 32'h00000000, 1'b0},
	'{32'h18, 1'b1, 32'h44, 32'h80000000, 1'b0}, '{32'h1c, 1'b0, 32'h00, 32'h00000000, 1'b0},
	'{32'h20, 1'b1, 32'h48, 32'h80000002, 1'b0}, '{32'h24, 1'b0, 32'h00, 32'h00000000, 1'b1},
	'{32'h28, 1'b1, 32'h4c, 32'h80000000, 1'b0}, '{32'h2c, 1'b0, 32'h00, 32'h00000000, 1'b0},
	'{32'h30, 1'b1, 32'h50, 32'h00000001, 1'b0}, '{32'h34, 1'b0, 32'h00, 32'h00000000, 1'b0},
	'{32'h38, 1'b1, 32'h54, 32'h00000000, 1'b0}, '{32'h3c, 1'b0, 32'h00, 32'h00000000, 1'b0},
	'{32'h40, 1'b1, 32'h58, 32'h00000001, 1'b0}, '{32'h44, 1'b0, 32'h00, 32'h00000000, 1'b0},
	'{32'h48, 1'b1, 32'h5c, 32'h00000000, 1'b0}, '{32'h4c, 1'b0, 32'h00, 32'h00000000, 1'b0},
	'{32'h50, 1'b1, 32'h60, 32'hF8000000, 1'b0}, '{32'h54, 1'b0, 32'h00, 32'h00000000, 1'b0},
	'{32'h58, 1'b1, 32'h64, 32'h08000000, 1'b0}, '{32'h5c, 1'b0, 32'h00, 32'h00000000, 1'b0},
	'{32'h60, 1'b1, 32'h68, 32'h80000000, 1'b0}, '{32'h64, 1'b0, 32'h00, 32'h00000000, 1'b0},
	'{32'h68, 1'b1, 32'h6c, 32'h00000002, 1'b0}, '{32'h6c, 1'b0, 32'h00, 32'h00000000, 1'b0},
	'{32'h70, 1'b1, 32'h70, 32'h80000003, 1'b0}, '{32'h74, 1'b0, 32'h00, 32'h00000000, 1'b0},
	'{32'h78, 1'b1, 32'h74, 32'hFFFFFFFD, 1'b0}, '{32'h7c, 1'b0, 32'h00, 32'h00000000, 1'b0},
	'{32'h80, 1'b1, 32'h78, 32'h7FFFFFFC, 1'b0}, '{32'h84, 1'b0, 32'h00, 32'h00000000, 1'b0},
	'{32'h88, 1'b1, 32'h7c, 32'h7FFFFFFF, 1'b0}, '{32'h8c, 1'b0, 32'h00, 32'h00000000, 1'b0},
	'{32'h90, 1'b1, 32'h80, 32'h00000002, 1'b0}, '{32'h94, 1'b0, 32'h00, 32'h00000000, 1'b0},
	'{32'h98, 1'b1, 32'h84, 32'h80008002, 1'b0}, '{32'h9c, 1'b0, 32'h00, 32'h00000000, 1'b0},
	'{32'ha0, 1'b1, 32'h88, 32'h80000000, 1'b0}, '{32'ha4, 1'b0, 32'h00, 32'h00000000, 1'b0},
	'{32'hac, 1'b0, 32'h00, 32'h00000000, 1'b0}, '{32'hb0, 1'b0, 32'h00, 32'h00000000, 1'b0},
	'{32'hb8, 1'b0, 32'h00, 32'h00000000, 1'b0}, '{32'hbc, 1'b1, 32'h8c, 32'h5A5A1234, 1'b0},
	'{32'hc0, 1'b0, 32'h00, 32'h00000000, 1'b0}, '{32'hc4, 1'b1, 32'h90, 32'h00000000, 1'b0}
};

// ==== tests/mips_core_tb.sv ====
// Testbench for the single-cycle MIPS core, runs the included program and checks the per-cycle trace
module mips_core_tb;

	`include "mips_program.svh"

	localparam int RESET_CYCLES = 4;
	localparam int CYCLE_LIMIT  = STEP_COUNT + RESET_CYCLES + 20;

	logic        clk;
	logic        rst;
	logic [31:0] pc;
	logic [31:0] instr;
	logic        memwrite;
	logic [31:0] memaddr;
	logic [31:0] writedata;
	logic [31:0] readdata;
	logic        arth_overflow_exception;
	int          cycle_count;

	mips_core #(.RESET_PC(32'h0)) u_mips_core (
		.clk(clk), .rst(rst), .pc(pc), .instr(instr), .memwrite(memwrite),
		.memaddr(memaddr), .writedata(writedata), .readdata(readdata),
		.arth_overflow_exception(arth_overflow_exception)
	);

	always #2 clk = ~clk;

	// Words past the end of the program read as sll $0,$0,0
	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		if ((addr >> 2) < PROG_LEN)
			return PROGRAM[addr >> 2];
		return 32'h0;
	endfunction

	function automatic logic [31:0] load_word(input logic [31:0] addr);
		if ((addr >> 2) < DATA_LEN)
			return DATA[addr >> 2];
		return 32'h0;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at time %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("*** FAILED ***");
			$fatal(1, "check failed");
		end
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
			$display("*** FAILED ***");
			$fatal(1, "timeout");
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		// A store word held in reset must stay off the bus
		instr = 32'hAC000000;
		readdata = 32'h0;
		cycle_count = 0;

		@(posedge clk);
		repeat (RESET_CYCLES - 1) begin
			#3;
			check_value("pc in reset", pc, 32'h0);
			check_value("memwrite in reset", {31'b0, memwrite}, 32'h0);
			@(posedge clk);
		end

		for (int s = 0; s < STEP_COUNT; s++) begin
			#1;
			rst = 1'b0;
			instr = fetch_word(pc);
			#1;
			readdata = load_word(memaddr);
			#1;
			check_value($sformatf("step %0d pc", s), pc, STEPS[s].pc);
			check_value($sformatf("step %0d memwrite", s), {31'b0, memwrite},
				{31'b0, STEPS[s].we});
			check_value($sformatf("step %0d overflow", s), {31'b0, arth_overflow_exception},
				{31'b0, STEPS[s].ovf});
			if (STEPS[s].we) begin
				check_value($sformatf("step %0d memaddr", s), memaddr, STEPS[s].addr);
				check_value($sformatf("step %0d writedata", s), writedata, STEPS[s].data);
			end
			@(posedge clk);
		end

		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== source/mips_core.sv ====
// Top of the single-cycle MIPS core, connects decode, registers, ALU and pc to the memory ports
module mips_core #(
	parameter mips_pkg::word_t RESET_PC = '0
) (
	input  logic            clk,
	input  logic            rst,
	output mips_pkg::word_t pc,
	input  mips_pkg::word_t instr,
	output logic            memwrite,
	output mips_pkg::word_t memaddr,
	output mips_pkg::word_t writedata,
	input  mips_pkg::word_t readdata,
	output logic            arth_overflow_exception
);
	import mips_pkg::*;

	reg_addr_t rs_addr;
	reg_addr_t rt_addr;
	reg_addr_t wr_addr;
	word_t     imm;
	shamt_t    shamt;
	alu_op_t   alu_op;
	logic      alu_src_imm;
	logic      reg_write;
	logic      mem_to_reg;
	logic      mem_write;
	logic      branch_eq;
	logic      branch_ne;
	logic      jump;
	word_t     rs_data;
	word_t     rt_data;
	word_t     alu_b;
	word_t     alu_result;
	word_t     wr_data;

	mips_control u_mips_control (
		.instr(instr), .rs_addr(rs_addr), .rt_addr(rt_addr), .wr_addr(wr_addr),
		.imm(imm), .shamt(shamt), .alu_op(alu_op), .alu_src_imm(alu_src_imm),
		.reg_write(reg_write), .mem_to_reg(mem_to_reg), .mem_write(mem_write),
		.branch_eq(branch_eq), .branch_ne(branch_ne), .jump(jump)
	);

	mips_regfile u_mips_regfile (
		.clk(clk), .rst(rst), .rs_addr(rs_addr), .rt_addr(rt_addr),
		.wr_addr(wr_addr), .wr_en(reg_write), .wr_data(wr_data),
		.rs_data(rs_data), .rt_data(rt_data)
	);

	assign alu_b = alu_src_imm ? imm : rt_data;

	mips_alu u_mips_alu (
		.alu_op(alu_op), .a(rs_data), .b(alu_b), .shamt(shamt),
		.result(alu_result), .overflow(arth_overflow_exception)
	);

	mips_pc_unit #(.RESET_PC(RESET_PC)) u_mips_pc_unit (
		.clk(clk), .rst(rst), .rs_data(rs_data), .rt_data(rt_data), .imm(imm),
		.jump_index(instr[25:0]), .branch_eq(branch_eq), .branch_ne(branch_ne),
		.jump(jump), .pc(pc)
	);

	// Loads write back memory data, all else the ALU result
	assign wr_data = mem_to_reg ? readdata : alu_result;

	// Keep stray stores off the bus while held in reset
	assign memwrite  = mem_write && !rst;
	assign memaddr   = alu_result;
	assign writedata = rt_data;

endmodule

// ==== source/mips_pc_unit.sv ====
// Program counter of the core, resolves branches and jumps and registers the next fetch address
module mips_pc_unit #(
	parameter mips_pkg::word_t RESET_PC = '0
) (
	input  logic            clk,
	input  logic            rst,
	input  mips_pkg::word_t rs_data,
	input  mips_pkg::word_t rt_data,
	input  mips_pkg::word_t imm,
	input  logic [25:0]     jump_index,
	input  logic            branch_eq,
	input  logic            branch_ne,
	input  logic            jump,
	output mips_pkg::word_t pc
);
	import mips_pkg::*;

	word_t pc_plus4;
	word_t branch_target;
	word_t jump_target;
	word_t pc_next;
	logic  taken;

	assign pc_plus4      = pc + 32'd4;
	assign branch_target = pc_plus4 + {imm[29:0], 2'b00};
	assign jump_target   = {pc_plus4[31:28], jump_index, 2'b00};

	assign taken = (branch_eq && rs_data == rt_data) || (branch_ne && rs_data != rt_data);

	// No delay slot, the target is fetched next
	assign pc_next = jump ? jump_target : taken ? branch_target : pc_plus4;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

	pc_aligned: assert property (
		@(posedge clk) disable iff (rst) pc[1:0] == 2'b00
	) else $error("pc %h is not word aligned", pc);

endmodule

// ==== source/mips_alu.sv ====
// Integer ALU of the core: add, sub, logic, compares, fixed shifts and LUI with overflow flag
module mips_alu (
	input  mips_pkg::alu_op_t alu_op,
	input  mips_pkg::word_t   a,
	input  mips_pkg::word_t   b,
	input  mips_pkg::shamt_t  shamt,
	output mips_pkg::word_t   result,
	output logic              overflow
);
	import mips_pkg::*;

	localparam int MSB = WORD_WIDTH - 1;

	word_t                sum;
	word_t                diff;
	logic                 add_ovf;
	logic                 sub_ovf;
	logic [WORD_WIDTH:0]  add_wide;
	logic [WORD_WIDTH:0]  sub_wide;

	assign sum  = a + b;
	assign diff = a - b;

	// Same-sign operands giving an opposite-sign sum
	assign add_ovf = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
	// Opposite-sign operands where the difference loses the sign of a
	assign sub_ovf = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);

	// Sign-extended results, top two bits differ when the value does not fit
	assign add_wide = {a[MSB], a} + {b[MSB], b};
	assign sub_wide = {a[MSB], a} - {b[MSB], b};

	always_comb begin
		overflow = 1'b0;
		case (alu_op)
			ALU_ADD: begin
				result   = sum;
				overflow = add_ovf;
			end
			ALU_ADDU: result = sum;
			ALU_SUB: begin
				result   = diff;
				overflow = sub_ovf;
			end
			ALU_SUBU: result = diff;
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			ALU_XOR:  result = a ^ b;
			ALU_NOR:  result = ~(a | b);
			ALU_SLT:  result = word_t'($signed(a) < $signed(b));
			ALU_SLTU: result = word_t'(a < b);
			ALU_SLL:  result = b << shamt;
			ALU_SRL:  result = b >> shamt;
			ALU_SRA:  result = word_t'($signed(b) >>> shamt);
			ALU_LUI:  result = {b[15:0], 16'h0000};
			default:  result = sum;
		endcase
		// Unsigned forms wrap silently
		ovf_signed_only: assert (overflow == (
			(alu_op == ALU_ADD) ? (add_wide[WORD_WIDTH] != add_wide[MSB]) :
			(alu_op == ALU_SUB) ? (sub_wide[WORD_WIDTH] != sub_wide[MSB]) : 1'b0))
			else $error("overflow wrong for op %s", alu_op.name());
	end

endmodule

// ==== source/mips_regfile.sv ====
// 32-entry register file with two asynchronous read ports and one clocked write port
module mips_regfile (
	input  logic                clk,
	input  logic                rst,
	input  mips_pkg::reg_addr_t rs_addr,
	input  mips_pkg::reg_addr_t rt_addr,
	input  mips_pkg::reg_addr_t wr_addr,
	input  logic                wr_en,
	input  mips_pkg::word_t     wr_data,
	output mips_pkg::word_t     rs_data,
	output mips_pkg::word_t     rt_data
);
	import mips_pkg::*;

	word_t regs [2**REG_ADDR_WIDTH];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**REG_ADDR_WIDTH; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// $zero is never written, so it holds its reset value
	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

	zero_reads_zero: assert property (
		@(posedge clk) disable iff (rst)
		((rs_addr == '0) |-> (rs_data == '0)) and ((rt_addr == '0) |-> (rt_data == '0))
	) else $error("register 0 read back nonzero");

endmodule

// ==== source/mips_control.sv ====
// Instruction decoder of the single-cycle core, turns one instruction word into datapath controls
module mips_control (
	input  mips_pkg::word_t     instr,
	output mips_pkg::reg_addr_t rs_addr,
	output mips_pkg::reg_addr_t rt_addr,
	output mips_pkg::reg_addr_t wr_addr,
	output mips_pkg::word_t     imm,
	output mips_pkg::shamt_t    shamt,
	output mips_pkg::alu_op_t   alu_op,
	output logic                alu_src_imm,
	output logic                reg_write,
	output logic                mem_to_reg,
	output logic                mem_write,
	output logic                branch_eq,
	output logic                branch_ne,
	output logic                jump
);
	import mips_pkg::*;

	opcode_t opcode;
	funct_t  funct;
	logic    reg_dst;
	logic    zero_ext;

	assign opcode  = opcode_t'(instr[31:26]);
	assign funct   = funct_t'(instr[5:0]);
	assign rs_addr = instr[25:21];
	assign rt_addr = instr[20:16];
	assign shamt   = instr[10:6];

	// R-type writes rd, everything else writes rt
	assign wr_addr = reg_dst ? instr[15:11] : instr[20:16];
	assign imm     = zero_ext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

	always_comb begin
		alu_op      = ALU_ADDU;
		alu_src_imm = 1'b0;
		reg_write   = 1'b0;
		reg_dst     = 1'b0;
		zero_ext    = 1'b0;
		mem_to_reg  = 1'b0;
		mem_write   = 1'b0;
		branch_eq   = 1'b0;
		branch_ne   = 1'b0;
		jump        = 1'b0;
		case (opcode)
			RTYPE: begin
				reg_dst   = 1'b1;
				reg_write = 1'b1;
				case (funct)
					ADD:     alu_op = ALU_ADD;
					ADDU:    alu_op = ALU_ADDU;
					SUB:     alu_op = ALU_SUB;
					SUBU:    alu_op = ALU_SUBU;
					AND:     alu_op = ALU_AND;
					OR:      alu_op = ALU_OR;
					XOR:     alu_op = ALU_XOR;
					NOR:     alu_op = ALU_NOR;
					SLT:     alu_op = ALU_SLT;
					SLTU:    alu_op = ALU_SLTU;
					SLL:     alu_op = ALU_SLL;
					SRL:     alu_op = ALU_SRL;
					SRA:     alu_op = ALU_SRA;
					default: reg_write = 1'b0;
				endcase
			end
			ADDI, ADDIU, SLTI, SLTIU, LUI: begin
				alu_src_imm = 1'b1;
				reg_write   = 1'b1;
				case (opcode)
					ADDI:    alu_op = ALU_ADD;
					SLTI:    alu_op = ALU_SLT;
					SLTIU:   alu_op = ALU_SLTU;
					LUI:     alu_op = ALU_LUI;
					default: alu_op = ALU_ADDU;
				endcase
			end
			ANDI, ORI, XORI: begin
				alu_src_imm = 1'b1;
				reg_write   = 1'b1;
				zero_ext    = 1'b1;
				alu_op      = (opcode == ANDI) ? ALU_AND : (opcode == ORI) ? ALU_OR : ALU_XOR;
			end
			LW: begin
				alu_src_imm = 1'b1;
				reg_write   = 1'b1;
				mem_to_reg  = 1'b1;
			end
			SW: begin
				alu_src_imm = 1'b1;
				mem_write   = 1'b1;
			end
			BEQ:     branch_eq = 1'b1;
			BNE:     branch_ne = 1'b1;
			J:       jump = 1'b1;
			default: ;
		endcase
		// A store never also writes back
		write_excl: assert (!(reg_write && mem_write))
			else $error("control drives reg_write and mem_write for instr %h", instr);
	end

endmodule

// ==== source/mips_pkg.sv ====
// Widths, word types and instruction encodings shared by every module of the MIPS core
package mips_pkg;

	localparam int WORD_WIDTH     = 32;
	localparam int REG_ADDR_WIDTH = 5;

	typedef logic [WORD_WIDTH-1:0]     word_t;
	typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
	typedef logic [4:0]                shamt_t;

	// Primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		J     = 6'h02,
		BEQ   = 6'h04,
		BNE   = 6'h05,
		ADDI  = 6'h08,
		ADDIU = 6'h09,
		SLTI  = 6'h0a,
		SLTIU = 6'h0b,
		ANDI  = 6'h0c,
		ORI   = 6'h0d,
		XORI  = 6'h0e,
		LUI   = 6'h0f,
		LW    = 6'h23,
		SW    = 6'h2b
	} opcode_t;

	// R-type function codes, instr[5:0]
	typedef enum logic [5:0] {
		SLL  = 6'h00,
		SRL  = 6'h02,
		SRA  = 6'h03,
		ADD  = 6'h20,
		ADDU = 6'h21,
		SUB  = 6'h22,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		XOR  = 6'h26,
		NOR  = 6'h27,
		SLT  = 6'h2a,
		SLTU = 6'h2b
	} funct_t;

	// Signed add and sub are the only ones that flag overflow
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_ADDU,
		ALU_SUB,
		ALU_SUBU,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI
	} alu_op_t;

endpackage
